// ==== rtl/periphPkg.sv ====
`default_nettype none

package periphPkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------
    typedef logic [11:0] wbAddrT;
    typedef logic [31:0] wbDataT;
    typedef logic [3:0]  wbSelT;

    // word offset inside a 16-byte device window
    typedef logic [1:0]  regOffT;

    typedef enum logic [1:0] {
        DEV_TIMER,
        DEV_SPI,
        DEV_SYS,
        DEV_NONE
    } devSelT;

    // ----------------------------------------------------------------------
    // address map
    // ----------------------------------------------------------------------
    localparam wbAddrT TIMER_BASE = 12'h000;
    localparam wbAddrT SPI_BASE   = 12'h100;
    localparam wbAddrT SYS_BASE   = 12'h200;

    // timer registers
    localparam regOffT MTIME_LO_OFF    = 2'd0;
    localparam regOffT MTIME_HI_OFF    = 2'd1;
    localparam regOffT MTIMECMP_LO_OFF = 2'd2;
    localparam regOffT MTIMECMP_HI_OFF = 2'd3;

    // spi registers
    localparam regOffT SPI_DATA_OFF   = 2'd0;
    localparam regOffT SPI_STATUS_OFF = 2'd1;

    // system controller, low byte of a write is the command
    localparam regOffT     SYS_CTRL_OFF = 2'd0;
    localparam logic [7:0] CMD_REBOOT   = 8'h77;
    localparam logic [7:0] CMD_POWEROFF = 8'h55;

endpackage

`default_nettype wire

// ==== rtl/wbBusSlave.sv ====
`timescale 1ns/100ps
`default_nettype none

module wbBusSlave (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cyc_i,
    input  wire                    stb_i,
    input  wire                    we_i,
    input  wire periphPkg::wbAddrT adr_i,
    input  wire periphPkg::wbDataT dat_i,
    input  wire periphPkg::wbSelT  sel_i,
    output periphPkg::wbDataT      dat_o,
    output logic                   ack_o,
    input  wire                    spiBusy_i,
    input  wire periphPkg::wbDataT timerRdData_i,
    input  wire periphPkg::wbDataT spiRdData_i,
    input  wire periphPkg::wbDataT sysRdData_i,
    output periphPkg::regOffT      off_o,
    output periphPkg::wbDataT      wrData_o,
    output periphPkg::wbSelT       wrSel_o,
    output logic                   timerRdEn_o,
    output logic                   timerWrEn_o,
    output logic                   spiRdEn_o,
    output logic                   spiWrEn_o,
    output logic                   sysWrEn_o
);
    import periphPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SPI,
        RESPOND
    } stateT;

    stateT  state;
    stateT  stateNext;
    devSelT dev;
    wbDataT rdMux;
    logic   spiDataWr;

    // window decode on the upper address bits
    always_comb begin
        if (adr_i[11:4] == TIMER_BASE[11:4]) begin
            dev = DEV_TIMER;
        end else if (adr_i[11:4] == SPI_BASE[11:4]) begin
            dev = DEV_SPI;
        end else if (adr_i[11:4] == SYS_BASE[11:4]) begin
            dev = DEV_SYS;
        end else begin
            dev = DEV_NONE;
        end
    end

    assign off_o     = adr_i[3:2];
    assign wrData_o  = dat_i;
    assign wrSel_o   = sel_i;
    assign spiDataWr = we_i && (dev == DEV_SPI) && (off_o == SPI_DATA_OFF);

    always_comb begin
        case (dev)
            DEV_TIMER: rdMux = timerRdData_i;
            DEV_SPI:   rdMux = spiRdData_i;
            DEV_SYS:   rdMux = sysRdData_i;
            default:   rdMux = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // access FSM
    // ----------------------------------------------------------------------
    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (cyc_i && stb_i) begin
                    // a new spi transfer must wait for the current one
                    stateNext = (spiDataWr && spiBusy_i) ? WAIT_SPI : RESPOND;
                end
            end
            WAIT_SPI: begin
                if (!(cyc_i && stb_i)) begin
                    stateNext = IDLE;
                end else if (!spiBusy_i) begin
                    stateNext = RESPOND;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // sample read data before the strobe can change device state
    always_ff @(posedge clk) begin
        if (stateNext == RESPOND) begin
            dat_o <= rdMux;
        end
    end

    assign ack_o       = (state == RESPOND);
    assign timerRdEn_o = ack_o && (dev == DEV_TIMER) && !we_i;
    assign timerWrEn_o = ack_o && (dev == DEV_TIMER) && we_i;
    assign spiRdEn_o   = ack_o && (dev == DEV_SPI) && !we_i;
    assign spiWrEn_o   = ack_o && (dev == DEV_SPI) && we_i;
    assign sysWrEn_o   = ack_o && (dev == DEV_SYS) && we_i;

endmodule

`default_nettype wire

// ==== rtl/mtimer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mtimer #(
    parameter int TICK_DIV = 100
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wrEn_i,
    input  wire periphPkg::regOffT off_i,
    input  wire periphPkg::wbDataT wrData_i,
    input  wire periphPkg::wbSelT  wrSel_i,
    output periphPkg::wbDataT      rdData_o,
    output logic [63:0]            mtime_o,
    output logic                   timerIrq_o
);
    import periphPkg::*;

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] divCnt;
    logic             tick;
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic [63:0]      mtimeNext;
    logic [63:0]      mtimecmpNext;

    // replace only the bytes enabled in sel
    function automatic wbDataT mergeBytes(wbDataT old, wbDataT data, wbSelT sel);
        wbDataT res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // tick divider
    // ----------------------------------------------------------------------
    assign tick = (divCnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            divCnt <= DIV_W'(TICK_DIV - 1);
        end else if (tick) begin
            divCnt <= DIV_W'(TICK_DIV - 1);
        end else begin
            divCnt <= divCnt - 1'b1;
        end
    end

    // written bytes override the advanced count
    always_comb begin
        mtimeNext    = tick ? mtime + 64'd1 : mtime;
        mtimecmpNext = mtimecmp;
        if (wrEn_i) begin
            case (off_i)
                MTIME_LO_OFF:
                    mtimeNext[31:0] = mergeBytes(mtimeNext[31:0], wrData_i, wrSel_i);
                MTIME_HI_OFF:
                    mtimeNext[63:32] = mergeBytes(mtimeNext[63:32], wrData_i, wrSel_i);
                MTIMECMP_LO_OFF:
                    mtimecmpNext[31:0] = mergeBytes(mtimecmp[31:0], wrData_i, wrSel_i);
                default:
                    mtimecmpNext[63:32] = mergeBytes(mtimecmp[63:32], wrData_i, wrSel_i);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '0;
        end else begin
            mtime    <= mtimeNext;
            mtimecmp <= mtimecmpNext;
        end
    end

    always_comb begin
        case (off_i)
            MTIME_LO_OFF:    rdData_o = mtime[31:0];
            MTIME_HI_OFF:    rdData_o = mtime[63:32];
            MTIMECMP_LO_OFF: rdData_o = mtimecmp[31:0];
            default:         rdData_o = mtimecmp[63:32];
        endcase
    end

    assign mtime_o    = mtime;
    assign timerIrq_o = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// ==== rtl/spiMaster.sv ====
`timescale 1ns/100ps
`default_nettype none

module spiMaster (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rdEn_i,
    input  wire                    wrEn_i,
    input  wire periphPkg::regOffT off_i,
    input  wire periphPkg::wbDataT wrData_i,
    input  wire periphPkg::wbSelT  wrSel_i,
    output periphPkg::wbDataT      rdData_o,
    output logic                   busy_o,
    output logic                   spiCs_o,
    output logic                   spiSck_o,
    output logic                   spiMosi_o,
    input  wire                    spiMiso_i
);
    import periphPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT_LO,
        SHIFT_HI,
        FINISH
    } stateT;

    stateT      state;
    logic [5:0] bitCnt;
    logic [5:0] loadLen;
    wbDataT     loadData;
    wbDataT     shiftReg;
    wbDataT     rxData;
    logic       rxValid;
    logic       start;
    logic       rxRead;

    assign start  = wrEn_i && (off_i == SPI_DATA_OFF) && (state == IDLE);
    assign rxRead = rdEn_i && (off_i == SPI_DATA_OFF);
    assign busy_o = (state != IDLE);

    // byte select picks the transfer length, payload goes MSB aligned
    // so the zeros below it end up above the received bits
    always_comb begin
        case (wrSel_i)
            4'b0001: begin
                loadLen  = 6'd8;
                loadData = {wrData_i[7:0], 24'b0};
            end
            4'b0011: begin
                loadLen  = 6'd16;
                loadData = {wrData_i[15:0], 16'b0};
            end
            default: begin
                loadLen  = 6'd32;
                loadData = wrData_i;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // transfer FSM, two clocks per bit
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            bitCnt    <= '0;
            spiCs_o   <= 1'b1;
            spiSck_o  <= 1'b0;
            spiMosi_o <= 1'b0;
            rxValid   <= 1'b0;
        end else begin
            if (rxRead) begin
                rxValid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= SHIFT_LO;
                        bitCnt    <= loadLen;
                        spiCs_o   <= 1'b0;
                        spiMosi_o <= loadData[31];
                    end
                end
                SHIFT_LO: begin
                    spiSck_o <= 1'b1;
                    state    <= SHIFT_HI;
                end
                SHIFT_HI: begin
                    // falling edge, present the next bit
                    spiSck_o  <= 1'b0;
                    spiMosi_o <= shiftReg[31];
                    bitCnt    <= bitCnt - 1'b1;
                    state     <= (bitCnt == 6'd1) ? FINISH : SHIFT_LO;
                end
                default: begin
                    spiCs_o <= 1'b1;
                    rxValid <= 1'b1;
                    state   <= IDLE;
                end
            endcase
        end
    end

    // miso is taken on the rising sck edge
    always_ff @(posedge clk) begin
        if (start) begin
            shiftReg <= loadData;
        end else if (state == SHIFT_LO) begin
            shiftReg <= {shiftReg[30:0], spiMiso_i};
        end
        if (state == FINISH) begin
            rxData <= shiftReg;
        end
    end

    always_comb begin
        case (off_i)
            SPI_DATA_OFF:   rdData_o = rxData;
            SPI_STATUS_OFF: rdData_o = {30'b0, rxValid, busy_o};
            default:        rdData_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/sysCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module sysCtrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wrEn_i,
    input  wire periphPkg::regOffT off_i,
    input  wire periphPkg::wbDataT wrData_i,
    input  wire periphPkg::wbSelT  wrSel_i,
    output logic                   reboot_o,
    output logic                   powerOff_o
);
    import periphPkg::*;

    logic cmdWr;

    // only the low byte carries a command
    assign cmdWr = wrEn_i && (off_i == SYS_CTRL_OFF) && wrSel_i[0];

    // pulses last one cycle, cleared again unless a new command arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            reboot_o   <= 1'b0;
            powerOff_o <= 1'b0;
        end else begin
            reboot_o   <= cmdWr && (wrData_i[7:0] == CMD_REBOOT);
            powerOff_o <= cmdWr && (wrData_i[7:0] == CMD_POWEROFF);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/periphTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module periphTop #(
    parameter int TICK_DIV = 100
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cyc_i,
    input  wire                    stb_i,
    input  wire                    we_i,
    input  wire periphPkg::wbAddrT adr_i,
    input  wire periphPkg::wbDataT dat_i,
    input  wire periphPkg::wbSelT  sel_i,
    output wire periphPkg::wbDataT dat_o,
    output wire                    ack_o,
    output wire                    spiCs_o,
    output wire                    spiSck_o,
    output wire                    spiMosi_o,
    input  wire                    spiMiso_i,
    output wire                    timerIrq_o,
    output wire [63:0]             mtime_o,
    output wire                    reboot_o,
    output wire                    powerOff_o
);
    import periphPkg::*;

    // shared device side of the bus
    regOffT off;
    wbDataT wrData;
    wbSelT  wrSel;
    wbDataT timerRdData;
    wbDataT spiRdData;
    logic   timerWrEn;
    logic   spiRdEn;
    logic   spiWrEn;
    logic   sysWrEn;
    logic   spiBusy;

    wbBusSlave i_wbBusSlave (
        .clk           (clk),
        .rst           (rst),
        .cyc_i         (cyc_i),
        .stb_i         (stb_i),
        .we_i          (we_i),
        .adr_i         (adr_i),
        .dat_i         (dat_i),
        .sel_i         (sel_i),
        .dat_o         (dat_o),
        .ack_o         (ack_o),
        .spiBusy_i     (spiBusy),
        .timerRdData_i (timerRdData),
        .spiRdData_i   (spiRdData),
        .sysRdData_i   ('0),
        .off_o         (off),
        .wrData_o      (wrData),
        .wrSel_o       (wrSel),
        .timerRdEn_o   (),
        .timerWrEn_o   (timerWrEn),
        .spiRdEn_o     (spiRdEn),
        .spiWrEn_o     (spiWrEn),
        .sysWrEn_o     (sysWrEn)
    );

    mtimer #(
        .TICK_DIV (TICK_DIV)
    ) i_mtimer (
        .clk        (clk),
        .rst        (rst),
        .wrEn_i     (timerWrEn),
        .off_i      (off),
        .wrData_i   (wrData),
        .wrSel_i    (wrSel),
        .rdData_o   (timerRdData),
        .mtime_o    (mtime_o),
        .timerIrq_o (timerIrq_o)
    );

    spiMaster i_spiMaster (
        .clk       (clk),
        .rst       (rst),
        .rdEn_i    (spiRdEn),
        .wrEn_i    (spiWrEn),
        .off_i     (off),
        .wrData_i  (wrData),
        .wrSel_i   (wrSel),
        .rdData_o  (spiRdData),
        .busy_o    (spiBusy),
        .spiCs_o   (spiCs_o),
        .spiSck_o  (spiSck_o),
        .spiMosi_o (spiMosi_o),
        .spiMiso_i (spiMiso_i)
    );

    sysCtrl i_sysCtrl (
        .clk        (clk),
        .rst        (rst),
        .wrEn_i     (sysWrEn),
        .off_i      (off),
        .wrData_i   (wrData),
        .wrSel_i    (wrSel),
        .reboot_o   (reboot_o),
        .powerOff_o (powerOff_o)
    );

endmodule

`default_nettype wire

// ==== verif/periphTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module periphTb;
    import periphPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int TICK_DIV   = 4;

    // cycle budget of each test, doubled for the watchdog
    localparam int RESET_CYCLES      = 10;
    localparam int TIMER_REG_CYCLES  = 250;
    localparam int MTIME_CYCLES      = 150;
    localparam int IRQ_CYCLES        = 300;
    localparam int SPI_LOOP_CYCLES   = 1100;
    localparam int SPI_STATUS_CYCLES = 150;
    localparam int SYS_CYCLES        = 100;
    localparam int WATCHDOG_CYCLES   = 2 * (RESET_CYCLES + TIMER_REG_CYCLES + MTIME_CYCLES
                                       + IRQ_CYCLES + SPI_LOOP_CYCLES + SPI_STATUS_CYCLES
                                       + SYS_CYCLES);

    localparam wbAddrT MTIME_LO_ADDR    = TIMER_BASE + 4 * MTIME_LO_OFF;
    localparam wbAddrT MTIME_HI_ADDR    = TIMER_BASE + 4 * MTIME_HI_OFF;
    localparam wbAddrT MTIMECMP_LO_ADDR = TIMER_BASE + 4 * MTIMECMP_LO_OFF;
    localparam wbAddrT MTIMECMP_HI_ADDR = TIMER_BASE + 4 * MTIMECMP_HI_OFF;
    localparam wbAddrT SPI_DATA_ADDR    = SPI_BASE + 4 * SPI_DATA_OFF;
    localparam wbAddrT SPI_STATUS_ADDR  = SPI_BASE + 4 * SPI_STATUS_OFF;
    localparam wbAddrT SYS_CTRL_ADDR    = SYS_BASE + 4 * SYS_CTRL_OFF;
    localparam wbAddrT UNMAPPED_ADDR    = 12'h3F0;

    logic        clk = 1'b0;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    wbAddrT      adr;
    wbDataT      datToDut;
    wbSelT       selToDut;
    wire wbDataT datFromDut;
    wire         ack;
    wire         spiCs;
    wire         spiSck;
    wire         spiMosi;
    wire         spiMiso;
    wire         timerIrq;
    wire [63:0]  mtime;
    wire         reboot;
    wire         powerOff;

    int ackWait;
    int sckRises;
    logic sckLast = 1'b0;
    int rebootPulses;
    int powerOffPulses;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // loopback so every transfer returns what it sent
    assign spiMiso = spiMosi;

    periphTop #(
        .TICK_DIV (TICK_DIV)
    ) i_periphTop (
        .clk        (clk),
        .rst        (rst),
        .cyc_i      (cyc),
        .stb_i      (stb),
        .we_i       (we),
        .adr_i      (adr),
        .dat_i      (datToDut),
        .sel_i      (selToDut),
        .dat_o      (datFromDut),
        .ack_o      (ack),
        .spiCs_o    (spiCs),
        .spiSck_o   (spiSck),
        .spiMosi_o  (spiMosi),
        .spiMiso_i  (spiMiso),
        .timerIrq_o (timerIrq),
        .mtime_o    (mtime),
        .reboot_o   (reboot),
        .powerOff_o (powerOff)
    );

    // ----------------------------------------------------------------------
    // monitors and watchdog
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (spiSck && !sckLast) begin
            sckRises++;
            assert (spiCs == 1'b0) else failRun("SCK rose while chip select was inactive");
        end
        sckLast = spiSck;
        if (reboot) begin
            rebootPulses++;
        end
        if (powerOff) begin
            powerOffPulses++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        failRun("watchdog timeout: the tests did not finish in time");
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else
            failRun($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                              name, expected, actual));
    endtask

    // expected register value after a byte-masked write
    function automatic wbDataT maskedUpdate(wbDataT old, wbDataT data, wbSelT sel);
        wbDataT mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic int spiLength(wbSelT sel);
        if (sel == 4'b0001) begin
            return 8;
        end else if (sel == 4'b0011) begin
            return 16;
        end
        return 32;
    endfunction

    function automatic wbDataT spiExpected(wbDataT data, wbSelT sel);
        if (sel == 4'b0001) begin
            return {24'h0, data[7:0]};
        end else if (sel == 4'b0011) begin
            return {16'h0, data[15:0]};
        end
        return data;
    endfunction

    // ----------------------------------------------------------------------
    // wishbone master
    // ----------------------------------------------------------------------
    task automatic finishAccess(output wbDataT rdData);
        ackWait = 0;
        do begin
            @(negedge clk);
            ackWait++;
        end while (!ack);
        rdData = datFromDut;
        // keep the request through the strobe edge, then release it
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        assert (!ack) else failRun("ack_o stayed high for more than one cycle");
    endtask

    task automatic wbWrite(input wbAddrT addr, input wbDataT data, input wbSelT sel);
        wbDataT unused;
        @(negedge clk);
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = 1'b1;
        adr      = addr;
        datToDut = data;
        selToDut = sel;
        finishAccess(unused);
    endtask

    task automatic wbRead(input wbAddrT addr, output wbDataT data);
        @(negedge clk);
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = 1'b0;
        adr      = addr;
        selToDut = 4'b1111;
        finishAccess(data);
        // reads are never held, ack follows one cycle after the request
        checkValue("bus read latency", 1, ackWait);
    endtask

    task automatic pollSpiDone();
        wbDataT st;
        do begin
            wbRead(SPI_STATUS_ADDR, st);
        end while (st[1:0] != 2'b10);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic timerRegisters();
        wbDataT cmpLo;
        wbDataT cmpHi;
        wbDataT data;
        wbDataT rd;
        wbSelT  sel;
        // mtimecmp starts at zero after reset
        cmpLo = '0;
        cmpHi = '0;
        for (int i = 0; i < 12; i++) begin
            data = $urandom;
            sel  = wbSelT'($urandom);
            if (i % 2 == 0) begin
                wbWrite(MTIMECMP_LO_ADDR, data, sel);
                cmpLo = maskedUpdate(cmpLo, data, sel);
            end else begin
                wbWrite(MTIMECMP_HI_ADDR, data, sel);
                cmpHi = maskedUpdate(cmpHi, data, sel);
            end
            wbRead(MTIMECMP_LO_ADDR, rd);
            checkValue("timer mtimecmp low byte write", cmpLo, rd);
            wbRead(MTIMECMP_HI_ADDR, rd);
            checkValue("timer mtimecmp high byte write", cmpHi, rd);
        end
        wbRead(UNMAPPED_ADDR, rd);
        checkValue("unmapped read", 0, rd);
    endtask

    task automatic mtimeAdvance();
        wbDataT first;
        wbDataT second;
        int     diff;
        wbWrite(MTIME_HI_ADDR, 32'h0, 4'b1111);
        wbWrite(MTIME_LO_ADDR, 32'h0, 4'b1111);
        wbRead(MTIME_LO_ADDR, first);
        assert (first <= 2) else failRun("mtime did not restart from zero after the write");
        repeat (40) @(negedge clk);
        wbRead(MTIME_LO_ADDR, second);
        diff = int'(second - first);
        assert (diff >= 40 / TICK_DIV - 2 && diff <= 40 / TICK_DIV + 2) else
            failRun($sformatf("CHECK FAILED mtime advance: expected %0d, actual %0d",
                              40 / TICK_DIV, diff));
    endtask

    task automatic timerInterrupt();
        wbDataT now;
        int     waited;
        wbRead(MTIME_LO_ADDR, now);
        wbWrite(MTIMECMP_HI_ADDR, 32'hFFFF_FFFF, 4'b1111);
        wbWrite(MTIMECMP_LO_ADDR, now + 32'd20, 4'b1111);
        wbWrite(MTIMECMP_HI_ADDR, 32'h0, 4'b1111);
        assert (!timerIrq) else failRun("timer interrupt high before mtime reached mtimecmp");
        waited = 0;
        while (!timerIrq) begin
            @(negedge clk);
            waited++;
            assert (waited <= 20 * TICK_DIV + 8) else failRun("timer interrupt never rose");
        end
        checkValue("timer interrupt mtime", {32'h0, now + 32'd20}, mtime);
        wbWrite(MTIMECMP_LO_ADDR, 32'hFFFF_FFFF, 4'b1111);
        wbWrite(MTIMECMP_HI_ADDR, 32'hFFFF_FFFF, 4'b1111);
        assert (!timerIrq) else failRun("timer interrupt still high with mtimecmp at all ones");
    endtask

    task automatic spiLoopback();
        wbSelT  sel;
        wbDataT data;
        wbDataT second;
        wbDataT rd;
        for (int i = 0; i < 6; i++) begin
            case (i % 3)
                0:       sel = 4'b0001;
                1:       sel = 4'b0011;
                default: sel = 4'b1111;
            endcase
            data     = $urandom;
            sckRises = 0;
            wbWrite(SPI_DATA_ADDR, data, sel);
            assert (spiCs == 1'b0) else failRun("chip select did not go low on the write");
            pollSpiDone();
            assert (spiCs == 1'b1) else failRun("chip select still low after the transfer");
            checkValue("spi sck count", spiLength(sel), sckRises);
            wbRead(SPI_DATA_ADDR, rd);
            checkValue("spi loopback data", spiExpected(data, sel), rd);
        end

        // second write has to wait for the first transfer
        data     = $urandom;
        second   = $urandom;
        sckRises = 0;
        wbWrite(SPI_DATA_ADDR, data, 4'b1111);
        wbWrite(SPI_DATA_ADDR, second, 4'b0001);
        assert (ackWait > 1) else failRun("second SPI write was not held during the transfer");
        wbRead(SPI_DATA_ADDR, rd);
        checkValue("spi back-to-back first", data, rd);
        pollSpiDone();
        wbRead(SPI_DATA_ADDR, rd);
        checkValue("spi back-to-back second", {24'h0, second[7:0]}, rd);
        checkValue("spi back-to-back sck count", 40, sckRises);
    endtask

    task automatic spiStatus();
        wbDataT st;
        wbDataT rd;
        wbWrite(SPI_DATA_ADDR, 32'h0000_00A5, 4'b0001);
        wbRead(SPI_STATUS_ADDR, st);
        checkValue("spi status while busy", 32'h1, st);
        pollSpiDone();
        wbRead(SPI_STATUS_ADDR, st);
        checkValue("spi status after transfer", 32'h2, st);
        wbRead(SPI_DATA_ADDR, rd);
        checkValue("spi status data", 32'hA5, rd);
        wbRead(SPI_STATUS_ADDR, st);
        checkValue("spi status after data read", 32'h0, st);
    endtask

    task automatic sysCommand(input wbDataT data, input wbSelT sel,
                              input int expReboot, input int expPowerOff);
        rebootPulses   = 0;
        powerOffPulses = 0;
        wbWrite(SYS_CTRL_ADDR, data, sel);
        repeat (3) @(negedge clk);
        checkValue("sys reboot pulses", expReboot, rebootPulses);
        checkValue("sys poweroff pulses", expPowerOff, powerOffPulses);
    endtask

    task automatic systemControl();
        logic [7:0] other;
        sysCommand({24'h0, CMD_REBOOT}, 4'b0001, 1, 0);
        sysCommand({24'h0, CMD_POWEROFF}, 4'b0001, 0, 1);
        sysCommand({24'h0, CMD_REBOOT}, 4'b1110, 0, 0);
        for (int i = 0; i < 4; i++) begin
            do begin
                other = 8'($urandom);
            end while (other == CMD_REBOOT || other == CMD_POWEROFF);
            sysCommand({24'h0, other}, 4'b1111, 0, 0);
        end
    endtask

    initial begin
        int unsigned seedInit;
        seedInit = $urandom(17309);
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datToDut = '0;
        selToDut = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        timerRegisters();
        mtimeAdvance();
        timerInterrupt();
        spiLoopback();
        spiStatus();
        systemControl();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/periphPkg.sv
rtl/wbBusSlave.sv
rtl/mtimer.sv
rtl/spiMaster.sv
rtl/sysCtrl.sv
rtl/periphTop.sv
verif/periphTb.sv
